//--- design/cpu_types_pkg.sv
package cpu_types_pkg;

    // **************************************************
    // Machine widths.
    // **************************************************

    // Physical address width of the core.
    localparam int PALEN = 32;

    // Number of implemented ASID bits.
    localparam int ASID_WID = 10;

    typedef logic [31:0] u32_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [1:0]  plv_t;

    // **************************************************
    // CSR instruction encodings.
    // **************************************************

    typedef enum logic [1:0] {
        CSR_OP_NONE = 2'd0,
        CSR_OP_RD   = 2'd1,
        CSR_OP_WR   = 2'd2,
        CSR_OP_XCHG = 2'd3
    } csr_op_t;

endpackage

//--- design/csr_op_unit.sv
module csr_op_unit
    import cpu_types_pkg::*, csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_req_t  req,
    input  u32_t      rd_data,
    output csr_addr_t addr,
    output logic      we,
    output u32_t      wr_data,
    output csr_resp_t resp
);

    logic valid_q;
    u32_t data_q;

    // Decode.
    assign addr = req.addr;
    assign we   = (req.op == CSR_OP_WR) || (req.op == CSR_OP_XCHG);

    // csrxchg keeps the old bits where the mask is clear.
    assign wr_data = (req.op == CSR_OP_XCHG) ? csr_merge(rd_data, req.wr_data, req.mask)
                                             : req.wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= (req.op != CSR_OP_NONE);
        end
    end

    // Old value, captured before the write lands.
    always_ff @(posedge clk) begin
        data_q <= rd_data;
    end

    assign resp.valid   = valid_q;
    assign resp.rd_data = data_q;

endmodule

//--- design/csr_pkg.sv
package csr_pkg;

    import cpu_types_pkg::*;

`include "csr_layout.svh"

    // **************************************************
    // CSR numbers.
    // **************************************************

    localparam csr_addr_t CSR_CRMD      = 14'h0;
    localparam csr_addr_t CSR_PRMD      = 14'h1;
    localparam csr_addr_t CSR_EUEN      = 14'h2;
    localparam csr_addr_t CSR_ECFG      = 14'h4;
    localparam csr_addr_t CSR_ESTAT     = 14'h5;
    localparam csr_addr_t CSR_ERA       = 14'h6;
    localparam csr_addr_t CSR_BADV      = 14'h7;
    localparam csr_addr_t CSR_EENTRY    = 14'hc;
    localparam csr_addr_t CSR_TLBIDX    = 14'h10;
    localparam csr_addr_t CSR_TLBEHI    = 14'h11;
    localparam csr_addr_t CSR_TLBELO0   = 14'h12;
    localparam csr_addr_t CSR_TLBELO1   = 14'h13;
    localparam csr_addr_t CSR_ASID      = 14'h18;
    localparam csr_addr_t CSR_PGDL      = 14'h19;
    localparam csr_addr_t CSR_PGDH      = 14'h1a;
    localparam csr_addr_t CSR_PGD       = 14'h1b;
    localparam csr_addr_t CSR_CPUID     = 14'h20;
    localparam csr_addr_t CSR_SAVE0     = 14'h30;
    localparam csr_addr_t CSR_SAVE1     = 14'h31;
    localparam csr_addr_t CSR_SAVE2     = 14'h32;
    localparam csr_addr_t CSR_SAVE3     = 14'h33;
    localparam csr_addr_t CSR_TLBRENTRY = 14'h88;

    // **************************************************
    // Register set and request structs.
    // **************************************************

    typedef struct packed {
        crmd_t         crmd;
        prmd_t         prmd;
        euen_t         euen;
        ecfg_t         ecfg;
        estat_t        estat;
        u32_t          era;
        u32_t          badv;
        eentry_t       eentry;
        tlbidx_t       tlbidx;
        tlbehi_t       tlbehi;
        tlbelo_t [1:0] tlbelo;
        asid_t         asid;
        pgd_t          pgdl;
        pgd_t          pgdh;
        pgd_t          pgd;
        cpuid_t        cpuid;
        u32_t [3:0]    save;
        eentry_t       tlbrentry;
    } csr_t;

    typedef struct packed {
        logic   we;
        crmd_t  crmd;
        prmd_t  prmd;
        estat_t estat;
        u32_t   era;
        u32_t   badv;
    } excp_wr_req_t;

    typedef struct packed {
        logic          we;
        tlbidx_t       tlbidx;
        tlbehi_t       tlbehi;
        tlbelo_t [1:0] tlbelo;
        asid_t         asid;
    } tlb_wr_req_t;

    typedef struct packed {
        csr_op_t   op;
        csr_addr_t addr;
        u32_t      wr_data;
        u32_t      mask;
    } csr_req_t;

    typedef struct packed {
        logic valid;
        u32_t rd_data;
    } csr_resp_t;

    typedef struct packed {
        logic   valid;
        logic   ertn;
        ecode_t ecode;
        u32_t   pc;
        u32_t   vaddr;
    } excp_in_t;

    typedef struct packed {
        logic valid;
        u32_t target;
    } redirect_t;

    // Bits set in mask come from new_val, the rest from old_val.
    function automatic u32_t csr_merge(u32_t old_val, u32_t new_val, u32_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

endpackage

//--- design/csr_regfile.sv
module csr_regfile
    import cpu_types_pkg::*, csr_pkg::*;
#(
    parameter int TLB_IDX_WID = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  csr_addr_t    addr,
    output u32_t         rd_data,
    input  logic         we,
    input  u32_t         wr_data,
    input  tlb_wr_req_t  tlb_wr_req,
    input  excp_wr_req_t excp_wr_req,
    output csr_t         csr
);

    // **************************************************
    // Writable bits per register.
    // **************************************************

    localparam u32_t MASK_CRMD   = 32'h0000_01ff;
    localparam u32_t MASK_PRMD   = 32'h0000_0007;
    localparam u32_t MASK_EUEN   = 32'h0000_0001;
    localparam u32_t MASK_ECFG   = 32'h0000_1bff;
    localparam u32_t MASK_ESTAT  = 32'h0000_0003;
    localparam u32_t MASK_ENTRY  = 32'hffff_ffc0;
    localparam u32_t MASK_TLBEHI = 32'hffff_e000;
    localparam u32_t MASK_PGD    = 32'hffff_f000;
    localparam u32_t MASK_ALL    = 32'hffff_ffff;
    localparam u32_t MASK_TLBIDX = 32'hbf00_0000 | ((32'd1 << TLB_IDX_WID) - 32'd1);
    localparam u32_t MASK_TLBELO = (((32'd1 << (PALEN - 4)) - 32'd1) & 32'hffff_ff00) |
                                   32'h0000_007f;
    localparam u32_t MASK_ASID   = (32'd1 << ASID_WID) - 32'd1;

    // Exception entry also sets esubcode and ecode.
    localparam u32_t MASK_ESTAT_EXCP = 32'h7fff_0003;

    // Only da is set out of reset.
    localparam u32_t CRMD_RESET = 32'h0000_0008;

    csr_t csr_q;

    // **************************************************
    // Storage with prioritized writers.
    // **************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_q      <= '0;
            csr_q.crmd <= crmd_t'(CRMD_RESET);
        end else if (excp_wr_req.we) begin
            csr_q.crmd  <= crmd_t'(csr_merge(csr_q.crmd, excp_wr_req.crmd, MASK_CRMD));
            csr_q.prmd  <= prmd_t'(csr_merge(csr_q.prmd, excp_wr_req.prmd, MASK_PRMD));
            csr_q.estat <= estat_t'(csr_merge(csr_q.estat, excp_wr_req.estat,
                                              MASK_ESTAT_EXCP));
            csr_q.era   <= excp_wr_req.era;
            csr_q.badv  <= excp_wr_req.badv;
        end else if (tlb_wr_req.we) begin
            // TLB read and search results.
            csr_q.tlbidx <= tlbidx_t'(csr_merge(csr_q.tlbidx, tlb_wr_req.tlbidx, MASK_TLBIDX));
            csr_q.tlbehi <= tlbehi_t'(csr_merge(csr_q.tlbehi, tlb_wr_req.tlbehi, MASK_TLBEHI));
            csr_q.tlbelo[0] <= tlbelo_t'(csr_merge(csr_q.tlbelo[0], tlb_wr_req.tlbelo[0],
                                                   MASK_TLBELO));
            csr_q.tlbelo[1] <= tlbelo_t'(csr_merge(csr_q.tlbelo[1], tlb_wr_req.tlbelo[1],
                                                   MASK_TLBELO));
            csr_q.asid <= asid_t'(csr_merge(csr_q.asid, tlb_wr_req.asid, MASK_ASID));
        end else if (we) begin
            case (addr)
                CSR_CRMD:      csr_q.crmd   <= crmd_t'(csr_merge(csr_q.crmd, wr_data, MASK_CRMD));
                CSR_PRMD:      csr_q.prmd   <= prmd_t'(csr_merge(csr_q.prmd, wr_data, MASK_PRMD));
                CSR_EUEN:      csr_q.euen   <= euen_t'(csr_merge(csr_q.euen, wr_data, MASK_EUEN));
                CSR_ECFG:      csr_q.ecfg   <= ecfg_t'(csr_merge(csr_q.ecfg, wr_data, MASK_ECFG));
                CSR_ESTAT:     csr_q.estat  <= estat_t'(csr_merge(csr_q.estat, wr_data,
                                                                  MASK_ESTAT));
                CSR_ERA:       csr_q.era    <= wr_data;
                CSR_BADV:      csr_q.badv   <= wr_data;
                CSR_EENTRY:    csr_q.eentry <= eentry_t'(csr_merge(csr_q.eentry, wr_data,
                                                                   MASK_ENTRY));
                CSR_TLBIDX:    csr_q.tlbidx <= tlbidx_t'(csr_merge(csr_q.tlbidx, wr_data,
                                                                   MASK_TLBIDX));
                CSR_TLBEHI:    csr_q.tlbehi <= tlbehi_t'(csr_merge(csr_q.tlbehi, wr_data,
                                                                   MASK_TLBEHI));
                CSR_TLBELO0:   csr_q.tlbelo[0] <= tlbelo_t'(csr_merge(csr_q.tlbelo[0], wr_data,
                                                                      MASK_TLBELO));
                CSR_TLBELO1:   csr_q.tlbelo[1] <= tlbelo_t'(csr_merge(csr_q.tlbelo[1], wr_data,
                                                                      MASK_TLBELO));
                CSR_ASID:      csr_q.asid   <= asid_t'(csr_merge(csr_q.asid, wr_data, MASK_ASID));
                CSR_PGDL:      csr_q.pgdl   <= pgd_t'(csr_merge(csr_q.pgdl, wr_data, MASK_PGD));
                CSR_PGDH:      csr_q.pgdh   <= pgd_t'(csr_merge(csr_q.pgdh, wr_data, MASK_PGD));
                CSR_SAVE0:     csr_q.save[0] <= csr_merge(csr_q.save[0], wr_data, MASK_ALL);
                CSR_SAVE1:     csr_q.save[1] <= csr_merge(csr_q.save[1], wr_data, MASK_ALL);
                CSR_SAVE2:     csr_q.save[2] <= csr_merge(csr_q.save[2], wr_data, MASK_ALL);
                CSR_SAVE3:     csr_q.save[3] <= csr_merge(csr_q.save[3], wr_data, MASK_ALL);
                CSR_TLBRENTRY: csr_q.tlbrentry <= eentry_t'(csr_merge(csr_q.tlbrentry, wr_data,
                                                                      MASK_ENTRY));
                // cpuid, pgd and unlisted numbers ignore writes.
                default: ;
            endcase
        end
    end

    // **************************************************
    // Published register set.
    // **************************************************

    // Reserved bits are never written, so they keep their reset zero.
    always_comb begin
        csr                = csr_q;
        csr.cpuid.coreid   = '0;
        csr.asid.asidbits  = 8'(ASID_WID);
        csr.pgd.base       = csr_q.badv[31] ? csr_q.pgdh.base : csr_q.pgdl.base;
    end

    always_comb begin
        case (addr)
            CSR_CRMD:      rd_data = csr.crmd;
            CSR_PRMD:      rd_data = csr.prmd;
            CSR_EUEN:      rd_data = csr.euen;
            CSR_ECFG:      rd_data = csr.ecfg;
            CSR_ESTAT:     rd_data = csr.estat;
            CSR_ERA:       rd_data = csr.era;
            CSR_BADV:      rd_data = csr.badv;
            CSR_EENTRY:    rd_data = csr.eentry;
            CSR_TLBIDX:    rd_data = csr.tlbidx;
            CSR_TLBEHI:    rd_data = csr.tlbehi;
            CSR_TLBELO0:   rd_data = csr.tlbelo[0];
            CSR_TLBELO1:   rd_data = csr.tlbelo[1];
            CSR_ASID:      rd_data = csr.asid;
            CSR_PGDL:      rd_data = csr.pgdl;
            CSR_PGDH:      rd_data = csr.pgdh;
            CSR_PGD:       rd_data = csr.pgd;
            CSR_CPUID:     rd_data = csr.cpuid;
            CSR_SAVE0:     rd_data = csr.save[0];
            CSR_SAVE1:     rd_data = csr.save[1];
            CSR_SAVE2:     rd_data = csr.save[2];
            CSR_SAVE3:     rd_data = csr.save[3];
            CSR_TLBRENTRY: rd_data = csr.tlbrentry;
            default:       rd_data = '0;
        endcase
    end

endmodule

//--- design/csr_top.sv
module csr_top
    import cpu_types_pkg::*, csr_pkg::*;
#(
    parameter int TLB_IDX_WID = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_req_t    csr_req,
    input  excp_in_t    excp_in,
    input  tlb_wr_req_t tlb_wr,
    output csr_resp_t   csr_resp,
    output redirect_t   redirect,
    output csr_t        csr_state
);

    csr_addr_t    csr_addr;
    u32_t         csr_rd_data;
    logic         csr_we;
    u32_t         csr_wr_data;
    excp_wr_req_t excp_wr_req;

    csr_regfile #(
        .TLB_IDX_WID (TLB_IDX_WID)
    ) u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (csr_addr),
        .rd_data     (csr_rd_data),
        .we          (csr_we),
        .wr_data     (csr_wr_data),
        .tlb_wr_req  (tlb_wr),
        .excp_wr_req (excp_wr_req),
        .csr         (csr_state)
    );

    csr_op_unit u_op_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (csr_req),
        .rd_data (csr_rd_data),
        .addr    (csr_addr),
        .we      (csr_we),
        .wr_data (csr_wr_data),
        .resp    (csr_resp)
    );

    excp_ctrl u_excp_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .excp     (excp_in),
        .csr      (csr_state),
        .wr_req   (excp_wr_req),
        .redirect (redirect)
    );

endmodule

//--- design/excp_ctrl.sv
module excp_ctrl
    import cpu_types_pkg::*, csr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  excp_in_t     excp,
    input  csr_t         csr,
    output excp_wr_req_t wr_req,
    output redirect_t    redirect
);

    logic valid_q;
    u32_t target_q;
    u32_t target_d;

    // **************************************************
    // CSR update for entry and return.
    // **************************************************

    always_comb begin
        wr_req.we    = excp.valid;
        wr_req.crmd  = csr.crmd;
        wr_req.prmd  = csr.prmd;
        wr_req.estat = csr.estat;
        wr_req.era   = csr.era;
        wr_req.badv  = csr.badv;
        if (excp.ertn) begin
            // Restore the saved mode.
            wr_req.crmd.plv = csr.prmd.pplv;
            wr_req.crmd.ie  = csr.prmd.pie;
        end else begin
            wr_req.prmd.pplv  = csr.crmd.plv;
            wr_req.prmd.pie   = csr.crmd.ie;
            wr_req.crmd.plv   = plv_t'(0);
            wr_req.crmd.ie    = 1'b0;
            wr_req.estat.ecode = excp.ecode;
            wr_req.era        = excp.pc;
            wr_req.badv       = excp.vaddr;
        end
    end

    // **************************************************
    // Redirect to fetch.
    // **************************************************

    assign target_d = excp.ertn ? csr.era : u32_t'(csr.eentry);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= excp.valid;
        end
    end

    always_ff @(posedge clk) begin
        target_q <= target_d;
    end

    assign redirect.valid  = valid_q;
    assign redirect.target = target_q;

endmodule

//--- include/csr_layout.svh
`ifndef CSR_LAYOUT_SVH
`define CSR_LAYOUT_SVH

// **************************************************
// Field layouts of the individual CSRs, MSB first.
// **************************************************

typedef struct packed {
    logic [22:0] r0_1;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    plv_t        plv;
} crmd_t;

typedef struct packed {
    logic [28:0] r0_1;
    logic        pie;
    plv_t        pplv;
} prmd_t;

typedef struct packed {
    logic [30:0] r0_1;
    logic        fpe;
} euen_t;

// Local interrupt enables are split around bit 10.
typedef struct packed {
    logic [18:0] r0_1;
    logic [1:0]  lie_hi;
    logic        r0_2;
    logic [9:0]  lie_lo;
} ecfg_t;

typedef struct packed {
    logic        r0_1;
    logic [8:0]  esubcode;
    ecode_t      ecode;
    logic [2:0]  r0_2;
    logic        ipi;
    logic        ti;
    logic        r0_3;
    logic [7:0]  hwi;
    logic [1:0]  swi;
} estat_t;

// Also used for tlbrentry.
typedef struct packed {
    logic [25:0] va;
    logic [5:0]  r0_1;
} eentry_t;

// Index is kept at its widest; the implemented width is set per core.
typedef struct packed {
    logic        ne;
    logic        r0_1;
    logic [5:0]  ps;
    logic [7:0]  r0_2;
    logic [15:0] index;
} tlbidx_t;

typedef struct packed {
    logic [18:0] vppn;
    logic [12:0] r0_1;
} tlbehi_t;

typedef struct packed {
    logic [35-PALEN:0] r0_1;
    logic [PALEN-13:0] ppn;
    logic              r0_2;
    logic              g;
    logic [1:0]        mat;
    plv_t              plv;
    logic              d;
    logic              v;
} tlbelo_t;

typedef struct packed {
    logic [7:0]           r0_1;
    logic [7:0]           asidbits;
    logic [15-ASID_WID:0] r0_2;
    logic [ASID_WID-1:0]  asid;
} asid_t;

// Shared by pgdl, pgdh and pgd.
typedef struct packed {
    logic [19:0] base;
    logic [11:0] r0_1;
} pgd_t;

typedef struct packed {
    logic [22:0] r0_1;
    logic [8:0]  coreid;
} cpuid_t;

`endif

//--- run_sim.sh
#!/bin/sh
# Build the CSR testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f sources.f --top-module csr_tb \
    -o csr_sim \
    && ./obj_dir/csr_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "TEST FAIL" sim.log || { echo "Simulation reported a failure"; exit 1; }

//--- sources.f
+incdir+include
design/cpu_types_pkg.sv
design/csr_pkg.sv
design/csr_regfile.sv
design/csr_op_unit.sv
design/excp_ctrl.sv
design/csr_top.sv
verification/tb_clkgen.sv
verification/csr_tb.sv

//--- verification/csr_tb.sv
module csr_tb
    import cpu_types_pkg::*, csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int   TLB_IDX_WID = 6;
    localparam int   MAX_WAIT    = 8;
    localparam int   NUM_LISTED  = 22;
    localparam u32_t IDX_BITS    = (32'd1 << TLB_IDX_WID) - 32'd1;
    localparam u32_t ELO_MASK    = (((32'd1 << (PALEN - 4)) - 32'd1) & ~32'h0000_00ff) |
                                   32'h0000_007f;

    logic        clk;
    logic        rst_n;
    csr_req_t    csr_req;
    excp_in_t    excp_in;
    tlb_wr_req_t tlb_wr;
    csr_resp_t   csr_resp;
    redirect_t   redirect;
    csr_t        csr_state;

    int value_errors;
    int protocol_errors;
    int timeout_errors;

    // Reference register values, indexed by CSR number.
    u32_t regs [0:16383];

    csr_addr_t listed [NUM_LISTED] = '{
        CSR_CRMD, CSR_PRMD, CSR_EUEN, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
        CSR_TLBIDX, CSR_TLBEHI, CSR_TLBELO0, CSR_TLBELO1, CSR_ASID, CSR_PGDL, CSR_PGDH,
        CSR_PGD, CSR_CPUID, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TLBRENTRY
    };

    tb_clkgen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (5)
    ) u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_top #(
        .TLB_IDX_WID (TLB_IDX_WID)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_req   (csr_req),
        .excp_in   (excp_in),
        .tlb_wr    (tlb_wr),
        .csr_resp  (csr_resp),
        .redirect  (redirect),
        .csr_state (csr_state)
    );

    // **************************************************
    // Reference model.
    // **************************************************

    function automatic u32_t write_mask(csr_addr_t a);
        case (a)
            CSR_CRMD:                   return 32'h0000_01ff;
            CSR_PRMD:                   return 32'h0000_0007;
            CSR_EUEN:                   return 32'h0000_0001;
            CSR_ECFG:                   return 32'h0000_1bff;
            CSR_ESTAT:                  return 32'h0000_0003;
            CSR_EENTRY, CSR_TLBRENTRY:  return 32'hffff_ffc0;
            CSR_TLBIDX:                 return 32'hbf00_0000 | IDX_BITS;
            CSR_TLBEHI:                 return 32'hffff_e000;
            CSR_TLBELO0, CSR_TLBELO1:   return ELO_MASK;
            CSR_ASID:                   return 32'h0000_03ff;
            CSR_PGDL, CSR_PGDH:         return 32'hffff_f000;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1,
            CSR_SAVE2, CSR_SAVE3:       return 32'hffff_ffff;
            default:                    return '0;
        endcase
    endfunction

    // Unlisted numbers, cpuid and pgd are never written, so they stay zero.
    function automatic u32_t model_read(csr_addr_t a);
        case (a)
            CSR_PGD:  return regs[CSR_BADV][31] ? regs[CSR_PGDH] : regs[CSR_PGDL];
            CSR_ASID: return regs[CSR_ASID] | (u32_t'(ASID_WID) << 16);
            default:  return regs[a];
        endcase
    endfunction

    function automatic void model_write(csr_addr_t a, u32_t d);
        u32_t m;
        m = write_mask(a);
        regs[a] = (regs[a] & ~m) | (d & m);
    endfunction

    function automatic void model_reset();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        regs[CSR_CRMD] = 32'h0000_0008;
    endfunction

    function automatic void model_tlb(tlb_wr_req_t t);
        model_write(CSR_TLBIDX, u32_t'(t.tlbidx));
        model_write(CSR_TLBEHI, u32_t'(t.tlbehi));
        model_write(CSR_TLBELO0, u32_t'(t.tlbelo[0]));
        model_write(CSR_TLBELO1, u32_t'(t.tlbelo[1]));
        model_write(CSR_ASID, u32_t'(t.asid));
    endfunction

    // Mode bits sit at 2:0 in both crmd and prmd.
    function automatic void model_exception(excp_in_t ex);
        u32_t old_crmd;
        u32_t old_prmd;
        old_crmd = regs[CSR_CRMD];
        old_prmd = regs[CSR_PRMD];
        if (ex.ertn) begin
            regs[CSR_CRMD] = {old_crmd[31:3], old_prmd[2:0]};
        end else begin
            regs[CSR_PRMD] = {old_prmd[31:3], old_crmd[2:0]};
            regs[CSR_CRMD] = {old_crmd[31:3], 3'b000};
            regs[CSR_ESTAT][21:16] = ex.ecode;
            regs[CSR_ERA] = ex.pc;
            regs[CSR_BADV] = ex.vaddr;
        end
    endfunction

    function automatic csr_t build_state();
        csr_t s;
        s.crmd      = crmd_t'(model_read(CSR_CRMD));
        s.prmd      = prmd_t'(model_read(CSR_PRMD));
        s.euen      = euen_t'(model_read(CSR_EUEN));
        s.ecfg      = ecfg_t'(model_read(CSR_ECFG));
        s.estat     = estat_t'(model_read(CSR_ESTAT));
        s.era       = model_read(CSR_ERA);
        s.badv      = model_read(CSR_BADV);
        s.eentry    = eentry_t'(model_read(CSR_EENTRY));
        s.tlbidx    = tlbidx_t'(model_read(CSR_TLBIDX));
        s.tlbehi    = tlbehi_t'(model_read(CSR_TLBEHI));
        s.tlbelo[0] = tlbelo_t'(model_read(CSR_TLBELO0));
        s.tlbelo[1] = tlbelo_t'(model_read(CSR_TLBELO1));
        s.asid      = asid_t'(model_read(CSR_ASID));
        s.pgdl      = pgd_t'(model_read(CSR_PGDL));
        s.pgdh      = pgd_t'(model_read(CSR_PGDH));
        s.pgd       = pgd_t'(model_read(CSR_PGD));
        s.cpuid     = cpuid_t'(model_read(CSR_CPUID));
        s.save[0]   = model_read(CSR_SAVE0);
        s.save[1]   = model_read(CSR_SAVE1);
        s.save[2]   = model_read(CSR_SAVE2);
        s.save[3]   = model_read(CSR_SAVE3);
        s.tlbrentry = eentry_t'(model_read(CSR_TLBRENTRY));
        return s;
    endfunction

    // **************************************************
    // Compare tasks.
    // **************************************************

    task automatic check_word(input string name, input u32_t exp, input u32_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected redirect %0b/%08h, actual %0b/%08h",
                     name, exp.valid, exp.target, act.valid, act.target);
            value_errors++;
        end
    endtask

    task automatic check_state(input string name, input csr_t exp, input csr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected state %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // **************************************************
    // Stimulus helpers.
    // **************************************************

    function automatic csr_req_t make_req(csr_op_t op, csr_addr_t addr, u32_t data, u32_t mask);
        csr_req_t q;
        q.op      = op;
        q.addr    = addr;
        q.wr_data = data;
        q.mask    = mask;
        return q;
    endfunction

    // Mostly listed CSRs, sometimes any 14-bit number.
    function automatic csr_addr_t pick_addr();
        u32_t r;
        int   k;
        r = $urandom;
        k = int'(r[31:16]) % NUM_LISTED;
        if (r[1:0] == 2'd0) begin
            return r[15:2];
        end
        return listed[k];
    endfunction

    function automatic excp_in_t random_excp(logic ertn);
        excp_in_t e;
        u32_t     r;
        r       = $urandom;
        e.valid = 1'b1;
        e.ertn  = ertn;
        e.ecode = r[5:0];
        e.pc    = $urandom;
        e.vaddr = $urandom;
        return e;
    endfunction

    function automatic tlb_wr_req_t random_tlb();
        tlb_wr_req_t t;
        t.we        = 1'b1;
        t.tlbidx    = tlbidx_t'($urandom);
        t.tlbehi    = tlbehi_t'($urandom);
        t.tlbelo[0] = tlbelo_t'($urandom);
        t.tlbelo[1] = tlbelo_t'($urandom);
        t.asid      = asid_t'($urandom);
        return t;
    endfunction

    task automatic set_idle();
        csr_req = '0;
        excp_in = '0;
        tlb_wr  = '0;
    endtask

    task automatic wait_resp(input string name, output logic seen);
        int cycles;
        cycles = 1;
        while (!csr_resp.valid && cycles < MAX_WAIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        seen = csr_resp.valid;
        if (!seen) begin
            $display("%s: no CSR response within %0d cycles", name, MAX_WAIT);
            timeout_errors++;
        end else if (cycles != 1) begin
            $display("%s: CSR response came %0d cycles after the request", name, cycles);
            protocol_errors++;
        end
    endtask

    task automatic wait_redirect(input string name, output logic seen);
        int cycles;
        cycles = 1;
        while (!redirect.valid && cycles < MAX_WAIT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        seen = redirect.valid;
        if (!seen) begin
            $display("%s: no redirect within %0d cycles", name, MAX_WAIT);
            timeout_errors++;
        end else if (cycles != 1) begin
            $display("%s: redirect came %0d cycles after the exception", name, cycles);
            protocol_errors++;
        end
    endtask

    // Starts and ends 10 ns after a rising edge.
    task automatic run_cycle(input string name, input csr_req_t req, input excp_in_t ex,
                             input tlb_wr_req_t tlb);
        u32_t      exp_rd;
        redirect_t exp_redir;
        logic      seen;
        exp_rd           = model_read(req.addr);
        exp_redir.valid  = 1'b1;
        exp_redir.target = ex.ertn ? regs[CSR_ERA] : regs[CSR_EENTRY];
        csr_req = req;
        excp_in = ex;
        tlb_wr  = tlb;
        // One writer per edge: exception, then TLB, then the instruction.
        if (ex.valid) begin
            model_exception(ex);
        end else if (tlb.we) begin
            model_tlb(tlb);
        end else if (req.op == CSR_OP_WR) begin
            model_write(req.addr, req.wr_data);
        end else if (req.op == CSR_OP_XCHG) begin
            model_write(req.addr, (exp_rd & ~req.mask) | (req.wr_data & req.mask));
        end
        @(posedge clk);
        #10;
        set_idle();
        // Strobes without a cause must stay low.
        if (req.op == CSR_OP_NONE && csr_resp.valid) begin
            $display("%s: CSR response valid without a request", name);
            protocol_errors++;
        end
        if (!ex.valid && redirect.valid) begin
            $display("%s: redirect valid without an exception", name);
            protocol_errors++;
        end
        if (req.op != CSR_OP_NONE) begin
            wait_resp(name, seen);
            if (seen) begin
                check_word(name, exp_rd, csr_resp.rd_data);
            end
        end
        if (ex.valid) begin
            wait_redirect(name, seen);
            if (seen) begin
                check_redirect(name, exp_redir, redirect);
            end
        end
        check_state(name, build_state(), csr_state);
    endtask

    // **************************************************
    // Test sequence.
    // **************************************************

    initial begin
        csr_op_t op;
        u32_t    r;
        int      cycles;
        set_idle();
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        void'($urandom(32'hbbbc_cfb6));
        model_reset();

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            timeout_errors++;
        end
        @(posedge clk);
        #10;

        // Reset values and quiet outputs.
        check_state("reset_values", build_state(), csr_state);
        for (int n = 0; n < 3; n++) begin
            if (csr_resp.valid || redirect.valid) begin
                $display("A valid output is high after reset with nothing pending");
                protocol_errors++;
            end
            @(posedge clk);
            #10;
        end

        for (int n = 0; n < 300; n++) begin
            r  = $urandom;
            op = r[0] ? CSR_OP_WR : CSR_OP_RD;
            run_cycle("csr_rd_wr", make_req(op, pick_addr(), $urandom, '0), '0, '0);
        end

        for (int n = 0; n < 150; n++) begin
            run_cycle("csr_xchg", make_req(CSR_OP_XCHG, pick_addr(), $urandom, $urandom),
                      '0, '0);
        end

        // Entry then return, from a random mode.
        for (int n = 0; n < 10; n++) begin
            run_cycle("excp_setup", make_req(CSR_OP_WR, CSR_CRMD, $urandom, '0), '0, '0);
            run_cycle("excp_setup", make_req(CSR_OP_WR, CSR_PRMD, $urandom, '0), '0, '0);
            run_cycle("excp_setup", make_req(CSR_OP_WR, CSR_EENTRY, $urandom, '0), '0, '0);
            run_cycle("excp_entry", '0, random_excp(1'b0), '0);
            run_cycle("excp_ertn", '0, random_excp(1'b1), '0);
        end

        for (int n = 0; n < 20; n++) begin
            run_cycle("tlb_write", '0, '0, random_tlb());
        end
        for (int n = 0; n < 20; n++) begin
            run_cycle("tlb_vs_csrwr", make_req(CSR_OP_WR, pick_addr(), $urandom, '0),
                      '0, random_tlb());
        end
        for (int n = 0; n < 10; n++) begin
            r = $urandom;
            run_cycle("excp_vs_tlb", make_req(CSR_OP_WR, pick_addr(), $urandom, '0),
                      random_excp(r[0]), random_tlb());
        end
        run_cycle("tlbidx_width", make_req(CSR_OP_WR, CSR_TLBIDX, '1, '0), '0, '0);
        run_cycle("tlbidx_width", make_req(CSR_OP_RD, CSR_TLBIDX, '0, '0), '0, '0);

        // pgd follows badv bit 31.
        for (int n = 0; n < 8; n++) begin
            r = $urandom;
            run_cycle("derived", make_req(CSR_OP_WR, CSR_PGDL, $urandom, '0), '0, '0);
            run_cycle("derived", make_req(CSR_OP_WR, CSR_PGDH, $urandom, '0), '0, '0);
            run_cycle("derived", make_req(CSR_OP_WR, CSR_BADV, {n[0], r[30:0]}, '0), '0, '0);
            run_cycle("derived_pgd", make_req(CSR_OP_RD, CSR_PGD, '0, '0), '0, '0);
            run_cycle("derived_asid", make_req(CSR_OP_RD, CSR_ASID, '0, '0), '0, '0);
            run_cycle("derived_cpuid", make_req(CSR_OP_RD, CSR_CPUID, '0, '0), '0, '0);
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verification/tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands a little after an edge, clear of the capture point.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 10);
        rst_n = 1'b1;
    end

endmodule
